// File: cfifo_settings.svh
/*
 * Credit FIFO build settings
 * Storage depth, data width and the largest credit count the
 * receiver can owe the sender
 */
`ifndef CFIFO_SETTINGS_SVH
`define CFIFO_SETTINGS_SVH

// Storage entries, also the credit count granted after reset
`define CFIFO_DEPTH 8

// Bits per data word
`define CFIFO_WIDTH 16

// Never more owed than there are slots
`define CFIFO_MAX_CREDIT `CFIFO_DEPTH

`endif

// File: cfifo_pkg.sv
/*
 * Credit FIFO types
 * Vector typedefs for data words, storage addresses, slot counts
 * and credit counts
 */
`default_nettype none

package cfifo_pkg;

`include "cfifo_settings.svh"

  // One payload word
  typedef logic [`CFIFO_WIDTH-1:0] data_t;

  // Storage index, 0 to depth-1
  typedef logic [$clog2(`CFIFO_DEPTH)-1:0] addr_t;

  // Slots or occupancy, 0 to depth inclusive
  typedef logic [$clog2(`CFIFO_DEPTH+1)-1:0] count_t;

  // Credits owed, 0 to max credit inclusive
  typedef logic [$clog2(`CFIFO_MAX_CREDIT+1)-1:0] credit_t;

endpackage : cfifo_pkg

`default_nettype wire

// File: cfifo_credit_receiver.sv
/*
 * Credit receiver
 * Holds the count of credits owed to the sender and hands them back
 * as registered one-cycle pulses, at most one per cycle, while the
 * sender does not stall credit return
 */
`timescale 1ns/100ps
`default_nettype none
`include "cfifo_settings.svh"

module cfifo_credit_receiver (
  input  logic clk,
  input  logic rst_n,
  input  logic push_credit_stall,
  input  logic pop_beat,
  output logic push_credit
);

  import cfifo_pkg::*;

  // Whole FIFO is owed to the sender out of reset
  localparam credit_t CREDIT_INIT = credit_t'(`CFIFO_DEPTH);

  credit_t credit_owed;
  credit_t credit_owed_next;
  logic    credit_issue;

  // --------------------------------------------------------------------------
  // Issue decision
  // --------------------------------------------------------------------------

  // Something owed and sender not stalling
  assign credit_issue = (credit_owed != '0) && !push_credit_stall;

  // Entry left storage adds one, issued pulse takes one
  always_comb begin
    credit_owed_next = credit_owed;
    if (pop_beat && !credit_issue) begin
      credit_owed_next = credit_owed + credit_t'(1);
    end else if (!pop_beat && credit_issue) begin
      credit_owed_next = credit_owed - credit_t'(1);
    end
  end

  // --------------------------------------------------------------------------
  // State
  // --------------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_owed <= CREDIT_INIT;
    end else begin
      credit_owed <= credit_owed_next;
    end
  end

  // Registered pulse to the sender
  // one cycle after the decision
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      push_credit <= 1'b0;
    end else begin
      push_credit <= credit_issue;
    end
  end

endmodule : cfifo_credit_receiver

`default_nettype wire

// File: cfifo_push_ctrl.sv
/*
 * Push controller
 * Writes each credited push into storage at a wrapping address,
 * signals the push beat and keeps the free-slot count and full flag
 */
`timescale 1ns/100ps
`default_nettype none
`include "cfifo_settings.svh"

module cfifo_push_ctrl (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push_valid,
  input  cfifo_pkg::data_t push_data,
  input  logic             pop_beat,
  output logic             ram_wr_valid,
  output cfifo_pkg::addr_t ram_wr_addr,
  output cfifo_pkg::data_t ram_wr_data,
  output logic             push_beat,
  output cfifo_pkg::count_t slots,
  output logic             full
);

  import cfifo_pkg::*;

  // Last storage index before the address wraps
  localparam addr_t ADDR_LAST = addr_t'(`CFIFO_DEPTH - 1);
  localparam count_t SLOTS_INIT = count_t'(`CFIFO_DEPTH);

  addr_t  wr_addr;
  count_t slots_next;
  logic   full_next;

  // --------------------------------------------------------------------------
  // Write side
  // --------------------------------------------------------------------------

  // Sender holds a credit, so every push is accepted
  assign push_beat    = push_valid;
  assign ram_wr_valid = push_valid;
  assign ram_wr_addr  = wr_addr;
  assign ram_wr_data  = push_data;

  // Advance after each write, wrap at the end of storage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_addr <= '0;
    end else if (push_beat) begin
      if (wr_addr == ADDR_LAST) begin
        wr_addr <= '0;
      end else begin
        wr_addr <= wr_addr + addr_t'(1);
      end
    end
  end

  // --------------------------------------------------------------------------
  // Slot accounting
  // --------------------------------------------------------------------------

  // Push takes a slot, pop gives one back
  // both together leave it unchanged
  always_comb begin
    slots_next = slots;
    if (push_beat && !pop_beat) begin
      slots_next = slots - count_t'(1);
    end else if (!push_beat && pop_beat) begin
      slots_next = slots + count_t'(1);
    end
  end

  assign full_next = (slots_next == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slots <= SLOTS_INIT;
    end else begin
      slots <= slots_next;
    end
  end

  // Full flag only moves on a beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (push_beat || pop_beat) begin
      full <= full_next;
    end
  end

endmodule : cfifo_push_ctrl

`default_nettype wire

// File: cfifo_ram.sv
/*
 * Flop storage array
 * One write port registered on the rising edge and one
 * combinational read port
 */
`timescale 1ns/100ps
`default_nettype none
`include "cfifo_settings.svh"

module cfifo_ram (
  input  logic             clk,
  input  logic             wr_valid,
  input  cfifo_pkg::addr_t wr_addr,
  input  cfifo_pkg::data_t wr_data,
  input  cfifo_pkg::addr_t rd_addr,
  output cfifo_pkg::data_t rd_data
);

  import cfifo_pkg::*;

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------

  data_t mem [`CFIFO_DEPTH];

  // Write port
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read port, no output register
  // same-cycle write is seen after the edge
  assign rd_data = mem[rd_addr];

endmodule : cfifo_ram

`default_nettype wire

// File: cfifo_pop_ctrl.sv
/*
 * Pop controller
 * Tracks how many entries sit in storage and moves the oldest one
 * into a registered valid/ready output stage, pulsing the pop beat
 * each time an entry leaves storage
 */
`timescale 1ns/100ps
`default_nettype none
`include "cfifo_settings.svh"

module cfifo_pop_ctrl (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push_beat,
  output cfifo_pkg::addr_t ram_rd_addr,
  input  cfifo_pkg::data_t ram_rd_data,
  output logic             pop_beat,
  output logic             pop_valid,
  output cfifo_pkg::data_t pop_data,
  input  logic             pop_ready
);

  import cfifo_pkg::*;

  localparam addr_t ADDR_LAST = addr_t'(`CFIFO_DEPTH - 1);

  addr_t  rd_addr;
  count_t occupancy;
  count_t occupancy_next;
  logic   stage_free;
  logic   stage_load;

  // --------------------------------------------------------------------------
  // Load decision
  // --------------------------------------------------------------------------

  // Output stage empty, or its word transfers this cycle
  assign stage_free = !pop_valid || pop_ready;

  // Something stored and room downstream
  assign stage_load = (occupancy != '0) && stage_free;

  // Entry leaves storage on every load
  assign pop_beat    = stage_load;
  assign ram_rd_addr = rd_addr;

  // --------------------------------------------------------------------------
  // Storage occupancy and read address
  // --------------------------------------------------------------------------

  always_comb begin
    occupancy_next = occupancy;
    if (push_beat && !stage_load) begin
      occupancy_next = occupancy + count_t'(1);
    end else if (!push_beat && stage_load) begin
      occupancy_next = occupancy - count_t'(1);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      occupancy <= '0;
    end else begin
      occupancy <= occupancy_next;
    end
  end

  // Follows the write address around the array
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_addr <= '0;
    end else if (stage_load) begin
      if (rd_addr == ADDR_LAST) begin
        rd_addr <= '0;
      end else begin
        rd_addr <= rd_addr + addr_t'(1);
      end
    end
  end

  // --------------------------------------------------------------------------
  // Output stage
  // --------------------------------------------------------------------------

  // Valid stays up while stalled, drops once taken with nothing behind
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pop_valid <= 1'b0;
    end else if (stage_free) begin
      pop_valid <= stage_load;
    end
  end

  // Payload only changes on a load, so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (stage_load) begin
      pop_data <= ram_rd_data;
    end
  end

endmodule : cfifo_pop_ctrl

`default_nettype wire

// File: cfifo_top.sv
/*
 * Credit FIFO top level
 * Credit receiver, push controller, flop storage and pop controller
 * joined into a credit/valid in, valid/ready out synchronous FIFO
 */
`timescale 1ns/100ps
`default_nettype none

module cfifo_top (
  input  logic              clk,
  input  logic              rst_n,
  // Push side
  input  logic              push_credit_stall,
  output logic              push_credit,
  input  logic              push_valid,
  input  cfifo_pkg::data_t  push_data,
  // Pop side
  output logic              pop_valid,
  output cfifo_pkg::data_t  pop_data,
  input  logic              pop_ready,
  // Status
  output cfifo_pkg::count_t slots,
  output logic              full
);

  import cfifo_pkg::*;

  // Storage write port
  logic  ram_wr_valid;
  addr_t ram_wr_addr;
  data_t ram_wr_data;

  // Storage read port
  addr_t ram_rd_addr;
  data_t ram_rd_data;

  // Beats between the controllers
  logic push_beat;
  logic pop_beat;

  // --------------------------------------------------------------------------
  // Input side
  // --------------------------------------------------------------------------

  cfifo_credit_receiver cfifo_credit_receiver_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .push_credit_stall (push_credit_stall),
    .pop_beat          (pop_beat),
    .push_credit       (push_credit)
  );

  // --------------------------------------------------------------------------
  // Push control and storage
  // --------------------------------------------------------------------------

  cfifo_push_ctrl cfifo_push_ctrl_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_valid   (push_valid),
    .push_data    (push_data),
    .pop_beat     (pop_beat),
    .ram_wr_valid (ram_wr_valid),
    .ram_wr_addr  (ram_wr_addr),
    .ram_wr_data  (ram_wr_data),
    .push_beat    (push_beat),
    .slots        (slots),
    .full         (full)
  );

  cfifo_ram cfifo_ram_inst (
    .clk      (clk),
    .wr_valid (ram_wr_valid),
    .wr_addr  (ram_wr_addr),
    .wr_data  (ram_wr_data),
    .rd_addr  (ram_rd_addr),
    .rd_data  (ram_rd_data)
  );

  // --------------------------------------------------------------------------
  // Output side
  // --------------------------------------------------------------------------

  cfifo_pop_ctrl cfifo_pop_ctrl_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_beat   (push_beat),
    .ram_rd_addr (ram_rd_addr),
    .ram_rd_data (ram_rd_data),
    .pop_beat    (pop_beat),
    .pop_valid   (pop_valid),
    .pop_data    (pop_data),
    .pop_ready   (pop_ready)
  );

endmodule : cfifo_top

`default_nettype wire

// File: cfifo_checker.sv
/*
 * Credit FIFO checker
 * Watches the DUT ports, keeps a reference queue of pushed words and
 * counts ordering, slot, credit, hold and reset errors
 */
`timescale 1ns/100ps
`default_nettype none
`include "cfifo_settings.svh"

module cfifo_checker (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              push_credit_stall,
  input  logic              push_credit,
  input  logic              push_valid,
  input  cfifo_pkg::data_t  push_data,
  input  logic              pop_valid,
  input  cfifo_pkg::data_t  pop_data,
  input  logic              pop_ready,
  input  cfifo_pkg::count_t slots,
  input  logic              full,
  input  logic              end_check,
  output int                data_errors,
  output int                slot_errors,
  output int                credit_errors,
  output int                hold_errors,
  output int                reset_errors
);

  import cfifo_pkg::*;

  localparam int DEPTH = `CFIFO_DEPTH;

  data_t expect_q[$];
  data_t expect_word;
  data_t pop_data_q;
  int    pushes;
  int    pops;
  int    credits_rcvd;
  int    exp_slots;
  logic  stall_q;
  logic  pop_valid_q;
  logic  pop_ready_q;
  logic  final_done;
  logic  reset_applied = 1'b0;

  // Free slots after the counted transfers
  // a word waiting in the output stage has already left storage
  function automatic int expected_slots(input int n_push, input int n_pop,
                                        input logic stage_full);
    return DEPTH - n_push + n_pop + (stage_full ? 1 : 0);
  endfunction

  task automatic show_mismatch(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    $display("Error: %s expected %h actual %h at %0t", name, expected, actual, $time);
  endtask

  // --------------------------------------------------------------------------
  // Compare once per cycle on ports sampled just before each edge
  // --------------------------------------------------------------------------

  always @(posedge clk) begin
    if (!rst_n) begin
      // Flops pick up their reset value at the first edge in reset
      if (reset_applied &&
          (push_credit !== 1'b0 || pop_valid !== 1'b0 || full !== 1'b0 ||
           slots !== count_t'(DEPTH))) begin
        reset_errors++;
        $display("Error: reset state push_credit %h pop_valid %h slots %h full %h",
                 push_credit, pop_valid, slots, full);
      end
      reset_applied = 1'b1;
      stall_q       = 1'b0;
      pop_valid_q   = 1'b0;
      pop_ready_q   = 1'b0;
      pop_data_q    = '0;
      final_done    = 1'b0;
    end else begin
      // Stalled output stage must hold
      if (pop_valid_q && !pop_ready_q) begin
        if (pop_valid !== 1'b1) begin
          hold_errors++;
          show_mismatch("pop_valid", 32'd1, 32'(pop_valid));
        end else if (pop_data !== pop_data_q) begin
          hold_errors++;
          show_mismatch("pop_data", 32'(pop_data_q), 32'(pop_data));
        end
      end

      // Slot count and full flag
      exp_slots = expected_slots(pushes, pops, pop_valid);
      if (int'(slots) != exp_slots) begin
        slot_errors++;
        show_mismatch("slots", 32'(exp_slots), 32'(slots));
      end
      if (full !== (exp_slots == 0)) begin
        slot_errors++;
        show_mismatch("full", 32'(exp_slots == 0), 32'(full));
      end

      // A push spends a credit, so it must find a free slot
      if (push_valid && slots == '0) begin
        credit_errors++;
        $display("Error: push arrived with storage full at %0t", $time);
      end
      // Credits held by the sender never exceed the depth
      if (credits_rcvd - pushes > DEPTH) begin
        credit_errors++;
        $display("Error: sender holds %0d credits, more than the depth", credits_rcvd - pushes);
      end
      if (stall_q && push_credit) begin
        credit_errors++;
        $display("Error: credit pulse right after a stalled cycle at %0t", $time);
      end

      // Order and data
      if (pop_valid && pop_ready) begin
        if (expect_q.size() == 0) begin
          data_errors++;
          $display("Error: word popped with nothing pushed at %0t", $time);
        end else begin
          expect_word = expect_q.pop_front();
          if (pop_data !== expect_word) begin
            data_errors++;
            show_mismatch("pop_data", 32'(expect_word), 32'(pop_data));
          end
        end
        pops++;
      end
      if (push_valid) begin
        expect_q.push_back(push_data);
        pushes++;
      end
      if (push_credit) begin
        credits_rcvd++;
      end

      // Drained state is checked only once
      if (end_check && !final_done) begin
        final_done = 1'b1;
        if (credits_rcvd - pushes != DEPTH) begin
          credit_errors++;
          $display("Sender holds %0d credits after drain instead of %0d",
                   credits_rcvd - pushes, DEPTH);
        end
        if (expect_q.size() != 0) begin
          data_errors++;
          $display("%0d pushed words never reached the pop side", expect_q.size());
        end
      end

      stall_q     = push_credit_stall;
      pop_valid_q = pop_valid;
      pop_ready_q = pop_ready;
      pop_data_q  = pop_data;
    end
  end

endmodule : cfifo_checker

`default_nettype wire

// File: tb_cfifo_top.sv
/*
 * Credit FIFO testbench
 * Clock, reset, a credit-holding sender model with LCG data, random
 * pop back-pressure and credit stall phases, drain and timeout
 */
`timescale 1ns/100ps
`default_nettype none
`include "cfifo_settings.svh"

module tb_cfifo_top;

  import cfifo_pkg::*;

  localparam int NUM_PUSHES   = 1000;
  localparam int DRAIN_MARGIN = 1000;
  // Up to three cycles per push with back-pressure and stall phases
  localparam int CYCLE_LIMIT  = NUM_PUSHES * 3 + DRAIN_MARGIN;

  logic   clk = 1'b0;
  logic   rst_n;
  logic   push_credit_stall;
  logic   push_credit;
  logic   push_valid;
  data_t  push_data;
  logic   pop_valid;
  data_t  pop_data;
  logic   pop_ready;
  count_t slots;
  logic   full;
  logic   end_check;

  int          data_errors;
  int          slot_errors;
  int          credit_errors;
  int          hold_errors;
  int          reset_errors;
  int          cycle;
  int          credits_held;
  int          push_total;
  logic [31:0] rand_state = 32'h78f6aa99;

  always #4 clk = ~clk;

  cfifo_top cfifo_top_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .push_credit_stall (push_credit_stall),
    .push_credit       (push_credit),
    .push_valid        (push_valid),
    .push_data         (push_data),
    .pop_valid         (pop_valid),
    .pop_data          (pop_data),
    .pop_ready         (pop_ready),
    .slots             (slots),
    .full              (full)
  );

  cfifo_checker checker_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .push_credit_stall (push_credit_stall),
    .push_credit       (push_credit),
    .push_valid        (push_valid),
    .push_data         (push_data),
    .pop_valid         (pop_valid),
    .pop_data          (pop_data),
    .pop_ready         (pop_ready),
    .slots             (slots),
    .full              (full),
    .end_check         (end_check),
    .data_errors       (data_errors),
    .slot_errors       (slot_errors),
    .credit_errors     (credit_errors),
    .hold_errors       (hold_errors),
    .reset_errors      (reset_errors)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // --------------------------------------------------------------------------
  // Sender model and pop side driven once per rising edge
  // --------------------------------------------------------------------------

  task automatic drive_cycle(input logic draining);
    logic [15:0] decide;
    // Credit in and push out during the cycle just ended
    if (push_credit) credits_held++;
    if (push_valid) credits_held--;
    rand_state = lcg_next(rand_state);
    decide     = rand_state[31:16];
    rand_state = lcg_next(rand_state);
    if (!draining && credits_held > 0 && decide[3:2] != 2'b00) begin
      push_valid <= 1'b1;
      push_data  <= data_t'(rand_state[31:16]);
      push_total++;
    end else begin
      push_valid <= 1'b0;
    end
    if (draining) begin
      pop_ready         <= 1'b1;
      push_credit_stall <= 1'b0;
    end else begin
      // Long back-pressure window followed by mostly ready
      pop_ready <= ((cycle % 400) >= 60) && (decide[1:0] != 2'b00);
      // Stall window plus the odd single-cycle stall
      push_credit_stall <= ((cycle % 300) >= 150 && (cycle % 300) < 180) ||
                           (decide[7:4] == 4'h0);
    end
  endtask

  task automatic finish_run(input logic timed_out);
    $display("Summary: errors data %0d slot %0d credit %0d hold %0d reset %0d",
             data_errors, slot_errors, credit_errors, hold_errors, reset_errors);
    if (timed_out || data_errors + slot_errors + credit_errors + hold_errors +
        reset_errors != 0) begin
      $display("tests failed");
    end else begin
      $display("all tests passed");
    end
    $finish;
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial begin
    rst_n             <= 1'b0;
    push_credit_stall <= 1'b0;
    push_valid        <= 1'b0;
    push_data         <= '0;
    pop_ready         <= 1'b0;
    end_check         <= 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    while (push_total < NUM_PUSHES) begin
      @(posedge clk);
      drive_cycle(1'b0);
    end
    // Drain until every credit is back with the sender
    while (credits_held != `CFIFO_DEPTH || pop_valid) begin
      @(posedge clk);
      drive_cycle(1'b1);
    end
    end_check <= 1'b1;
    @(posedge clk);
    @(posedge clk);
    @(negedge clk);
    finish_run(1'b0);
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      finish_run(1'b1);
    end
  end

endmodule : tb_cfifo_top

`default_nettype wire

// File: cfifo_top.f
+incdir+.
cfifo_pkg.sv
cfifo_credit_receiver.sv
cfifo_push_ctrl.sv
cfifo_ram.sv
cfifo_pop_ctrl.sv
cfifo_top.sv
cfifo_checker.sv
tb_cfifo_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the credit FIFO testbench with Verilator, run it and scan the log

rm -f sim.log
verilator --binary --timing -f cfifo_top.f --top-module tb_cfifo_top -o sim_cfifo \
  && ./obj_dir/sim_cfifo > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "FAIL: build or run error"; exit 1; }

cat sim.log
grep -q "tests failed" sim.log \
  && { echo "FAIL"; exit 1; } \
  || { echo "PASS"; exit 0; }
